/* stats.f */
+incdir+src
+incdir+testbench
src/stats_pkg.sv
src/pkt_event_counters.sv
src/status_sync.sv
src/status_csr.sv
src/stats_top.sv
testbench/stats_tb.sv

/* Makefile */
# Verilator build and run for the statistics block

TOP = stats_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build the testbench with Verilator and run it"
	@echo "  make clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f stats.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* testbench/stats_tb_tasks.svh */
`ifndef STATS_TB_TASKS_SVH
`define STATS_TB_TASKS_SVH

//////////////////////////////////////////////////
// Checks
//////////////////////////////////////////////////

task automatic word_equals(input string name, input logic [`STAT_CNT_W-1:0] actual,
                           input logic [`STAT_CNT_W-1:0] expected);
    assert (actual === expected) else begin
        $display("[FAIL] t=%0t %s expected 0x%08h actual 0x%08h",
                 $time, name, expected, actual);
        $display("TESTBENCH FAILED");
        $fatal(1, "Wrong register value");
    end
endtask

task automatic flag_equals(input string name, input logic actual, input logic expected);
    assert (actual === expected) else begin
        $display("[FAIL] t=%0t %s expected %0b actual %0b", $time, name, expected, actual);
        $display("TESTBENCH FAILED");
        $fatal(1, "Wrong flag value");
    end
endtask

function automatic status_addr_t addr_of(input logic [`STAT_AWIDTH-1:0] region,
                                         input logic [`STAT_OFS_W-1:0] offset);
    status_addr_t a;
    a        = '0;
    a.region = region;
    a.offset = offset;
    return a;
endfunction

function automatic logic [`STAT_CNT_W-1:0] reg_expect(input logic [`STAT_OFS_W-1:0] offset);
    case (offset)
        `REG_IN_PKT:          return exp_in;
        `REG_OUT_PKT:         return exp_out;
        `REG_OUT_1_PKT:       return exp_out_1;
        `REG_DMA_PKT:         return exp_dma;
        `REG_CPU_NOMATCH_PKT: return exp_nomatch;
        `REG_CPU_MATCH_PKT:   return exp_match;
        `REG_MAX_DM2SM:       return exp_max_dm2sm;
        `REG_MAX_NF2PDU:      return exp_max_nf2pdu;
        `REG_CTRL:            return exp_ctrl;
        default:              return `STAT_DEFAULT_READ;
    endcase
endfunction

function automatic string reg_name(input logic [`STAT_OFS_W-1:0] offset);
    case (offset)
        `REG_IN_PKT:          return "in_pkt";
        `REG_OUT_PKT:         return "out_pkt";
        `REG_OUT_1_PKT:       return "out_1_pkt";
        `REG_DMA_PKT:         return "dma_pkt";
        `REG_CPU_NOMATCH_PKT: return "cpu_nomatch_pkt";
        `REG_CPU_MATCH_PKT:   return "cpu_match_pkt";
        `REG_MAX_DM2SM:       return "max_dm2sm";
        `REG_MAX_NF2PDU:      return "max_nf2pdu";
        `REG_CTRL:            return "ctrl";
        default:              return "unmapped";
    endcase
endfunction

//////////////////////////////////////////////////
// Status bus
//////////////////////////////////////////////////

// Counters settle, then the two-flop sync and the read path
task automatic wait_quiet();
    repeat (3) @(negedge clk_pkt);
    repeat (5) @(negedge clk_status);
endtask

task automatic write_reg(input logic [`STAT_AWIDTH-1:0] region,
                         input logic [`STAT_OFS_W-1:0] offset,
                         input logic [`STAT_CNT_W-1:0] data);
    @(negedge clk_status);
    status_addr_i      = addr_of(region, offset);
    status_writedata_i = data;
    status_write_i     = 1'b1;
    if (region == `TOP_REG) begin
        exp_ctrl = (offset == `REG_CTRL) ? data : '0;
    end
    @(negedge clk_status);
    status_write_i = 1'b0;
    @(negedge clk_status);
endtask

// Response lands two edges after the request, for one cycle
task automatic read_reg(input logic [`STAT_OFS_W-1:0] offset);
    @(negedge clk_status);
    status_addr_i = addr_of(`TOP_REG, offset);
    status_read_i = 1'b1;
    exp_resp++;
    @(negedge clk_status);
    status_read_i = 1'b0;
    flag_equals("status_readdata_valid_o", status_readdata_valid_o, 1'b0);
    @(negedge clk_status);
    flag_equals("status_readdata_valid_o", status_readdata_valid_o, 1'b1);
    word_equals(reg_name(offset), status_readdata_o, reg_expect(offset));
    @(negedge clk_status);
    flag_equals("status_readdata_valid_o", status_readdata_valid_o, 1'b0);
endtask

task automatic read_all_regs();
    for (int i = 0; i < 9; i++) begin
        read_reg(REG_MAP[i]);
    end
endtask

task automatic read_foreign(input logic [`STAT_AWIDTH-1:0] region,
                            input logic [`STAT_OFS_W-1:0] offset);
    @(negedge clk_status);
    status_addr_i = addr_of(region, offset);
    status_read_i = 1'b1;
    @(negedge clk_status);
    status_read_i = 1'b0;
    repeat (4) begin
        flag_equals("status_readdata_valid_o", status_readdata_valid_o, 1'b0);
        @(negedge clk_status);
    end
endtask

// One request per cycle, checking request t-2 at each step
task automatic burst_read_all();
    for (int t = 0; t < 12; t++) begin
        @(negedge clk_status);
        if (t >= 2 && t < 11) begin
            flag_equals("status_readdata_valid_o", status_readdata_valid_o, 1'b1);
            word_equals(reg_name(REG_MAP[t-2]), status_readdata_o, reg_expect(REG_MAP[t-2]));
        end else begin
            flag_equals("status_readdata_valid_o", status_readdata_valid_o, 1'b0);
        end
        if (t < 9) begin
            status_addr_i = addr_of(`TOP_REG, REG_MAP[t]);
            status_read_i = 1'b1;
            exp_resp++;
        end else begin
            status_read_i = 1'b0;
        end
    end
endtask

//////////////////////////////////////////////////
// Packet-side event drivers
//////////////////////////////////////////////////

task automatic run_streams(input int beats);
    logic [31:0] rnd;
    repeat (beats) begin
        @(negedge clk_pkt);
        rnd           = $urandom;
        in_eop_i      = rnd[0];
        in_valid_i    = rnd[1];
        out_eop_i     = rnd[2];
        out_valid_i   = rnd[3];
        out_ready_i   = rnd[4];
        out_1_eop_i   = rnd[5];
        out_1_valid_i = rnd[6];
        out_1_ready_i = rnd[7];
        // Input side ignores ready
        if (in_eop_i && in_valid_i) begin
            exp_in += 1;
        end
        if (out_eop_i && out_valid_i && out_ready_i) begin
            exp_out += 1;
        end
        if (out_1_eop_i && out_1_valid_i && out_1_ready_i) begin
            exp_out_1 += 1;
        end
    end
    @(negedge clk_pkt);
    in_eop_i      = 1'b0;
    in_valid_i    = 1'b0;
    out_eop_i     = 1'b0;
    out_valid_i   = 1'b0;
    out_ready_i   = 1'b0;
    out_1_eop_i   = 1'b0;
    out_1_valid_i = 1'b0;
    out_1_ready_i = 1'b0;
endtask

task automatic run_pdu_dma(input int beats);
    logic [31:0] rnd;
    repeat (beats + 1) begin
        @(negedge clk_pkt);
        flag_equals("pcie_rb_update_valid_o", pcie_rb_update_valid_o,
                    rb_update_i & ~disable_pcie_i);
        rnd             = $urandom;
        rb_update_i     = rnd[0];
        disable_pcie_i  = rnd[1];
        pdumeta_valid_i = rnd[2];
        pdumeta_ready_i = rnd[3];
        pdumeta_data_i  = rnd[31:4];
        // DMA counts whether or not PCIe is disabled
        if (rb_update_i) begin
            exp_dma += 1;
        end
        if (pdumeta_valid_i && pdumeta_ready_i) begin
            if (pdumeta_data_i.action == `ACTION_MATCH) begin
                exp_match += 1;
            end else if (pdumeta_data_i.action == `ACTION_NOMATCH) begin
                exp_nomatch += 1;
            end
        end
    end
    @(negedge clk_pkt);
    flag_equals("pcie_rb_update_valid_o", pcie_rb_update_valid_o,
                rb_update_i & ~disable_pcie_i);
    rb_update_i     = 1'b0;
    disable_pcie_i  = 1'b0;
    pdumeta_valid_i = 1'b0;
    pdumeta_ready_i = 1'b0;
    pdumeta_data_i  = '0;
endtask

task automatic run_fills(input int beats);
    logic [31:0] rnd;
    int          shift;
    repeat (beats) begin
        @(negedge clk_pkt);
        rnd           = $urandom;
        shift         = $urandom_range(31, 0);
        fill_dm2sm_i  = rnd >> shift;
        rnd           = $urandom;
        shift         = $urandom_range(31, 0);
        fill_nf2pdu_i = rnd >> shift;
        if (fill_dm2sm_i > exp_max_dm2sm) begin
            exp_max_dm2sm = fill_dm2sm_i;
        end
        if (fill_nf2pdu_i > exp_max_nf2pdu) begin
            exp_max_nf2pdu = fill_nf2pdu_i;
        end
    end
    @(negedge clk_pkt);
    fill_dm2sm_i  = '0;
    fill_nf2pdu_i = '0;
endtask

`endif

/* testbench/stats_tb.sv */
`timescale 1ns/1ps
`include "stats_params.svh"

module stats_tb;
    import stats_pkg::*;

    localparam int STREAM_BEATS = 200;
    localparam int PDU_BEATS    = 1500;
    localparam int FILL_BEATS   = 1000;
    // Packet beats in status cycles, plus reset and register reads
    localparam int SEQ_CYCLES   = (STREAM_BEATS + PDU_BEATS + FILL_BEATS) * 7 / 10 + 1000;
    localparam int MAX_CYCLES   = 2 * SEQ_CYCLES;

    localparam logic [`STAT_OFS_W-1:0] REG_MAP [9] = '{
        `REG_IN_PKT, `REG_OUT_PKT, `REG_OUT_1_PKT, `REG_DMA_PKT, `REG_CPU_NOMATCH_PKT,
        `REG_CPU_MATCH_PKT, `REG_MAX_DM2SM, `REG_MAX_NF2PDU, `REG_CTRL
    };

    logic                   clk_status;
    logic                   clk_pkt;
    logic                   rst;
    logic                   in_eop_i;
    logic                   in_valid_i;
    logic                   out_eop_i;
    logic                   out_valid_i;
    logic                   out_ready_i;
    logic                   out_1_eop_i;
    logic                   out_1_valid_i;
    logic                   out_1_ready_i;
    logic                   rb_update_i;
    logic                   disable_pcie_i;
    logic                   pcie_rb_update_valid_o;
    pdu_meta_t              pdumeta_data_i;
    logic                   pdumeta_valid_i;
    logic                   pdumeta_ready_i;
    logic [`FILL_W-1:0]     fill_dm2sm_i;
    logic [`FILL_W-1:0]     fill_nf2pdu_i;
    status_addr_t           status_addr_i;
    logic                   status_read_i;
    logic                   status_write_i;
    logic [`STAT_CNT_W-1:0] status_writedata_i;
    logic [`STAT_CNT_W-1:0] status_readdata_o;
    logic                   status_readdata_valid_o;

    //////////////////////////////////////////////////
    // Scoreboard
    //////////////////////////////////////////////////

    logic [`STAT_CNT_W-1:0] exp_in;
    logic [`STAT_CNT_W-1:0] exp_out;
    logic [`STAT_CNT_W-1:0] exp_out_1;
    logic [`STAT_CNT_W-1:0] exp_dma;
    logic [`STAT_CNT_W-1:0] exp_nomatch;
    logic [`STAT_CNT_W-1:0] exp_match;
    logic [`STAT_CNT_W-1:0] exp_max_dm2sm;
    logic [`STAT_CNT_W-1:0] exp_max_nf2pdu;
    logic [`STAT_CNT_W-1:0] exp_ctrl;
    logic [`STAT_CNT_W-1:0] ctrl_data;
    int                     exp_resp;
    int                     resp_seen = 0;
    int                     cycle_count = 0;

    `include "stats_tb_tasks.svh"

    stats_top dut (
        .clk_status              (clk_status),
        .clk_pkt                 (clk_pkt),
        .rst                     (rst),
        .in_eop_i                (in_eop_i),
        .in_valid_i              (in_valid_i),
        .out_eop_i               (out_eop_i),
        .out_valid_i             (out_valid_i),
        .out_ready_i             (out_ready_i),
        .out_1_eop_i             (out_1_eop_i),
        .out_1_valid_i           (out_1_valid_i),
        .out_1_ready_i           (out_1_ready_i),
        .rb_update_i             (rb_update_i),
        .disable_pcie_i          (disable_pcie_i),
        .pcie_rb_update_valid_o  (pcie_rb_update_valid_o),
        .pdumeta_data_i          (pdumeta_data_i),
        .pdumeta_valid_i         (pdumeta_valid_i),
        .pdumeta_ready_i         (pdumeta_ready_i),
        .fill_dm2sm_i            (fill_dm2sm_i),
        .fill_nf2pdu_i           (fill_nf2pdu_i),
        .status_addr_i           (status_addr_i),
        .status_read_i           (status_read_i),
        .status_write_i          (status_write_i),
        .status_writedata_i      (status_writedata_i),
        .status_readdata_o       (status_readdata_o),
        .status_readdata_valid_o (status_readdata_valid_o)
    );

    initial begin
        clk_status = 1'b0;
        forever #50 clk_status = ~clk_status;
    end

    initial begin
        clk_pkt = 1'b0;
        forever #35 clk_pkt = ~clk_pkt;
    end

    always @(posedge clk_status) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "Timeout: run went past %0d status clock cycles", MAX_CYCLES);
        end
    end

    // Count every response pulse on the bus
    always @(negedge clk_status) begin
        if (status_readdata_valid_o === 1'b1) begin
            resp_seen++;
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(41));
        rst                = 1'b1;
        in_eop_i           = 1'b0;
        in_valid_i         = 1'b0;
        out_eop_i          = 1'b0;
        out_valid_i        = 1'b0;
        out_ready_i        = 1'b0;
        out_1_eop_i        = 1'b0;
        out_1_valid_i      = 1'b0;
        out_1_ready_i      = 1'b0;
        rb_update_i        = 1'b0;
        disable_pcie_i     = 1'b0;
        pdumeta_data_i     = '0;
        pdumeta_valid_i    = 1'b0;
        pdumeta_ready_i    = 1'b0;
        fill_dm2sm_i       = '0;
        fill_nf2pdu_i      = '0;
        status_addr_i      = '0;
        status_read_i      = 1'b0;
        status_write_i     = 1'b0;
        status_writedata_i = '0;
        exp_in             = '0;
        exp_out            = '0;
        exp_out_1          = '0;
        exp_dma            = '0;
        exp_nomatch        = '0;
        exp_match          = '0;
        exp_max_dm2sm      = '0;
        exp_max_nf2pdu     = '0;
        exp_ctrl           = '0;
        exp_resp           = 0;

        repeat (16) @(negedge clk_status);
        rst = 1'b0;
        wait_quiet();

        // Reset values and the unmapped pattern
        read_all_regs();
        read_reg(8'd9);

        run_streams(STREAM_BEATS);
        run_pdu_dma(PDU_BEATS);
        run_fills(FILL_BEATS);
        wait_quiet();
        read_all_regs();

        // Control register
        ctrl_data = $urandom;
        write_reg(`TOP_REG, `REG_CTRL, ctrl_data);
        read_reg(`REG_CTRL);
        write_reg(`TOP_REG, `REG_OUT_PKT, $urandom);
        read_reg(`REG_CTRL);
        ctrl_data = $urandom | 32'h1;
        write_reg(`TOP_REG, `REG_CTRL, ctrl_data);
        write_reg(2'd1, `REG_CTRL, ~ctrl_data);
        write_reg(2'd3, `REG_IN_PKT, $urandom);
        read_reg(`REG_CTRL);
        read_foreign(2'd2, `REG_CTRL);
        read_foreign(2'd1, `REG_IN_PKT);
        read_reg(`REG_IN_PKT);

        burst_read_all();
        repeat (4) @(negedge clk_status);

        if (resp_seen == exp_resp) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Saw %0d read responses for %0d reads", resp_seen, exp_resp);
            $display("TESTBENCH FAILED");
            $fatal(1, "Read response count does not match the reads issued");
        end
    end

endmodule

/* src/stats_top.sv */
`timescale 1ns/1ps
`include "stats_params.svh"

module stats_top (
    input  logic                       clk_status,
    input  logic                       clk_pkt,
    input  logic                       rst,
    // Packet streams
    input  logic                       in_eop_i,
    input  logic                       in_valid_i,
    input  logic                       out_eop_i,
    input  logic                       out_valid_i,
    input  logic                       out_ready_i,
    input  logic                       out_1_eop_i,
    input  logic                       out_1_valid_i,
    input  logic                       out_1_ready_i,
    // DMA ring buffer and CPU metadata
    input  logic                       rb_update_i,
    input  logic                       disable_pcie_i,
    output logic                       pcie_rb_update_valid_o,
    input  stats_pkg::pdu_meta_t       pdumeta_data_i,
    input  logic                       pdumeta_valid_i,
    input  logic                       pdumeta_ready_i,
    input  logic [`FILL_W-1:0]         fill_dm2sm_i,
    input  logic [`FILL_W-1:0]         fill_nf2pdu_i,
    // Status bus
    input  stats_pkg::status_addr_t    status_addr_i,
    input  logic                       status_read_i,
    input  logic                       status_write_i,
    input  logic [`STAT_CNT_W-1:0]     status_writedata_i,
    output logic [`STAT_CNT_W-1:0]     status_readdata_o,
    output logic                       status_readdata_valid_o
);
    import stats_pkg::*;

    pkt_events_t     events;
    status_req_t     status_req;
    stats_snapshot_t snapshot_pkt;
    stats_snapshot_t snapshot_status;
    logic            cpu_pkt;

    //////////////////////////////////////////////////
    // Event strobes
    //////////////////////////////////////////////////

    // Input side has no ready term
    assign events.in_pkt     = in_eop_i & in_valid_i;
    assign events.out_pkt    = out_eop_i & out_valid_i & out_ready_i;
    assign events.out_1_pkt  = out_1_eop_i & out_1_valid_i & out_1_ready_i;
    // DMA is counted even while PCIe is disabled
    assign events.dma_update = rb_update_i;

    assign cpu_pkt             = pdumeta_valid_i & pdumeta_ready_i;
    assign events.cpu_match    = cpu_pkt & (pdumeta_data_i.action == `ACTION_MATCH);
    assign events.cpu_nomatch  = cpu_pkt & (pdumeta_data_i.action == `ACTION_NOMATCH);

    assign pcie_rb_update_valid_o = disable_pcie_i ? 1'b0 : rb_update_i;

    assign status_req.addr      = status_addr_i;
    assign status_req.read      = status_read_i;
    assign status_req.write     = status_write_i;
    assign status_req.writedata = status_writedata_i;

    pkt_event_counters u_counters (
        .clk_pkt       (clk_pkt),
        .rst           (rst),
        .events_i      (events),
        .fill_dm2sm_i  (fill_dm2sm_i),
        .fill_nf2pdu_i (fill_nf2pdu_i),
        .snapshot_o    (snapshot_pkt)
    );

    status_sync u_sync (
        .clk_status (clk_status),
        .snapshot_i (snapshot_pkt),
        .snapshot_o (snapshot_status)
    );

    status_csr u_csr (
        .clk_status       (clk_status),
        .rst              (rst),
        .req_i            (status_req),
        .snapshot_i       (snapshot_status),
        .readdata_o       (status_readdata_o),
        .readdata_valid_o (status_readdata_valid_o)
    );

endmodule

/* src/status_csr.sv */
`timescale 1ns/1ps
`include "stats_params.svh"

module status_csr (
    input  logic                       clk_status,
    input  logic                       rst,
    input  stats_pkg::status_req_t     req_i,
    input  stats_pkg::stats_snapshot_t snapshot_i,
    output logic [`STAT_CNT_W-1:0]     readdata_o,
    output logic                       readdata_valid_o
);
    import stats_pkg::*;

    status_req_t            req_r;
    logic                   region_hit;
    logic                   read_hit;
    logic                   write_hit;
    logic [`STAT_CNT_W-1:0] read_mux;
    logic [`STAT_CNT_W-1:0] ctrl_r;

    //////////////////////////////////////////////////
    // Request register
    //////////////////////////////////////////////////

    always_ff @(posedge clk_status) begin
        req_r <= req_i;
        if (rst) begin
            req_r.read  <= 1'b0;
            req_r.write <= 1'b0;
        end
    end

    assign region_hit = (req_r.addr.region == `TOP_REG);
    assign read_hit   = req_r.read & region_hit;
    assign write_hit  = req_r.write & region_hit;

    //////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////

    always_comb begin
        case (req_r.addr.offset)
            `REG_IN_PKT:          read_mux = snapshot_i.in_pkt;
            `REG_OUT_PKT:         read_mux = snapshot_i.out_pkt;
            `REG_OUT_1_PKT:       read_mux = snapshot_i.out_1_pkt;
            `REG_DMA_PKT:         read_mux = snapshot_i.dma_pkt;
            `REG_CPU_NOMATCH_PKT: read_mux = snapshot_i.cpu_nomatch_pkt;
            `REG_CPU_MATCH_PKT:   read_mux = snapshot_i.cpu_match_pkt;
            `REG_MAX_DM2SM:       read_mux = snapshot_i.max_dm2sm;
            `REG_MAX_NF2PDU:      read_mux = snapshot_i.max_nf2pdu;
            `REG_CTRL:            read_mux = ctrl_r;
            default:              read_mux = `STAT_DEFAULT_READ;
        endcase
    end

    // Other regions get no response at all
    always_ff @(posedge clk_status) begin
        if (rst) begin
            readdata_valid_o <= 1'b0;
        end else begin
            readdata_valid_o <= read_hit;
        end
    end

    always_ff @(posedge clk_status) begin
        if (read_hit) begin
            readdata_o <= read_mux;
        end
    end

    //////////////////////////////////////////////////
    // Control register
    //////////////////////////////////////////////////

    // Any other offset in the region clears it
    always_ff @(posedge clk_status) begin
        if (rst) begin
            ctrl_r <= '0;
        end else if (write_hit) begin
            if (req_r.addr.offset == `REG_CTRL) begin
                ctrl_r <= req_r.writedata;
            end else begin
                ctrl_r <= '0;
            end
        end
    end

endmodule

/* src/status_sync.sv */
`timescale 1ns/1ps

module status_sync (
    input  logic                       clk_status,
    input  stats_pkg::stats_snapshot_t snapshot_i,
    output stats_pkg::stats_snapshot_t snapshot_o
);
    import stats_pkg::*;

    // First stage, may go metastable on a packet-domain update
    stats_snapshot_t snap_r1;

    //////////////////////////////////////////////////
    // Two-stage re-timing into clk_status
    //////////////////////////////////////////////////

    // Counters are only read after the packet side goes quiet,
    // so a plain per-bit double flop is enough here
    always_ff @(posedge clk_status) begin
        snap_r1    <= snapshot_i;
        snapshot_o <= snap_r1;
    end

endmodule

/* src/pkt_event_counters.sv */
`timescale 1ns/1ps
`include "stats_params.svh"

module pkt_event_counters (
    input  logic                       clk_pkt,
    input  logic                       rst,
    input  stats_pkg::pkt_events_t     events_i,
    input  logic [`FILL_W-1:0]         fill_dm2sm_i,
    input  logic [`FILL_W-1:0]         fill_nf2pdu_i,
    output stats_pkg::stats_snapshot_t snapshot_o
);
    import stats_pkg::*;

    localparam int NUM_EVENTS = $bits(pkt_events_t);
    localparam int NUM_FILLS  = 2;

    logic [1:0]             rst_sync;
    logic                   rst_pkt;
    logic [NUM_EVENTS-1:0]  event_vec;
    logic [`STAT_CNT_W-1:0] event_cnt [NUM_EVENTS];
    logic [`FILL_W-1:0]     fill_lvl  [NUM_FILLS];
    logic [`FILL_W-1:0]     fill_max  [NUM_FILLS];

    //////////////////////////////////////////////////
    // Reset bridge into clk_pkt
    //////////////////////////////////////////////////

    always_ff @(posedge clk_pkt) begin
        rst_sync <= {rst_sync[0], rst};
    end

    assign rst_pkt = rst_sync[1];

    //////////////////////////////////////////////////
    // Event counters
    //////////////////////////////////////////////////

    // Index order follows the register map
    assign event_vec = {
        events_i.cpu_match,
        events_i.cpu_nomatch,
        events_i.dma_update,
        events_i.out_1_pkt,
        events_i.out_pkt,
        events_i.in_pkt
    };

    always_ff @(posedge clk_pkt) begin
        if (rst_pkt) begin
            for (int i = 0; i < NUM_EVENTS; i++) begin
                event_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_EVENTS; i++) begin
                // Free running, wraps at full scale
                if (event_vec[i]) begin
                    event_cnt[i] <= event_cnt[i] + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // FIFO high-water marks
    //////////////////////////////////////////////////

    assign fill_lvl[0] = fill_dm2sm_i;
    assign fill_lvl[1] = fill_nf2pdu_i;

    always_ff @(posedge clk_pkt) begin
        if (rst_pkt) begin
            for (int i = 0; i < NUM_FILLS; i++) begin
                fill_max[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_FILLS; i++) begin
                if (fill_lvl[i] > fill_max[i]) begin
                    fill_max[i] <= fill_lvl[i];
                end
            end
        end
    end

    // Snapshot in register order
    assign snapshot_o.in_pkt          = event_cnt[0];
    assign snapshot_o.out_pkt         = event_cnt[1];
    assign snapshot_o.out_1_pkt       = event_cnt[2];
    assign snapshot_o.dma_pkt         = event_cnt[3];
    assign snapshot_o.cpu_nomatch_pkt = event_cnt[4];
    assign snapshot_o.cpu_match_pkt   = event_cnt[5];
    assign snapshot_o.max_dm2sm       = fill_max[0];
    assign snapshot_o.max_nf2pdu      = fill_max[1];

endmodule

/* src/stats_pkg.sv */
`include "stats_params.svh"

package stats_pkg;

    // Status bus address, region in the top bits
    typedef struct packed {
        logic [`STAT_AWIDTH-1:0]                        region;
        logic [`STAT_ADDR_W-`STAT_AWIDTH-`STAT_OFS_W-1:0] unused;
        logic [`STAT_OFS_W-1:0]                         offset;
    } status_addr_t;

    typedef struct packed {
        status_addr_t            addr;
        logic                    read;
        logic                    write;
        logic [`STAT_CNT_W-1:0]  writedata;
    } status_req_t;

    // Action code sits in the top bits
    typedef struct packed {
        logic [`PDU_ACT_W-1:0]             action;
        logic [`PDU_META_W-`PDU_ACT_W-1:0] fields;
    } pdu_meta_t;

    // One strobe per counted event, packet clock
    typedef struct packed {
        logic in_pkt;
        logic out_pkt;
        logic out_1_pkt;
        logic dma_update;
        logic cpu_match;
        logic cpu_nomatch;
    } pkt_events_t;

    // Counter values in register order
    typedef struct packed {
        logic [`STAT_CNT_W-1:0] in_pkt;
        logic [`STAT_CNT_W-1:0] out_pkt;
        logic [`STAT_CNT_W-1:0] out_1_pkt;
        logic [`STAT_CNT_W-1:0] dma_pkt;
        logic [`STAT_CNT_W-1:0] cpu_nomatch_pkt;
        logic [`STAT_CNT_W-1:0] cpu_match_pkt;
        logic [`STAT_CNT_W-1:0] max_dm2sm;
        logic [`STAT_CNT_W-1:0] max_nf2pdu;
    } stats_snapshot_t;

endpackage

/* src/stats_params.svh */
`ifndef STATS_PARAMS_SVH
`define STATS_PARAMS_SVH

//////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////

// Counter and status data width
`define STAT_CNT_W          32
`define STAT_ADDR_W         30
`define STAT_OFS_W          8
// Region select, top bits of the status address
`define STAT_AWIDTH         2
`define FILL_W              32

// Region code served by this block
`define TOP_REG             2'd0

//////////////////////////////////////////////////
// Register offsets
//////////////////////////////////////////////////

`define REG_IN_PKT          8'd0
`define REG_OUT_PKT         8'd1
`define REG_OUT_1_PKT       8'd2
`define REG_DMA_PKT         8'd3
`define REG_CPU_NOMATCH_PKT 8'd4
`define REG_CPU_MATCH_PKT   8'd5
`define REG_MAX_DM2SM       8'd6
`define REG_MAX_NF2PDU      8'd7
`define REG_CTRL            8'd8

// Unmapped offset pattern
`define STAT_DEFAULT_READ   32'hDEADBEEF

// PDU metadata
`define PDU_META_W          28
`define PDU_ACT_W           3
`define ACTION_MATCH        3'd2
`define ACTION_NOMATCH      3'd1

`endif
